/* trace_pkg.sv */
// TCB trace monitor shared types
// bus request/response structs, tracker records and the retirement record,
// used by the trackers, the merger and the testbench

package trace_pkg;

  ////////////////////
  // plain vectors
  ////////////////////

  // byte address on either bus
  typedef logic [32-1:0] addr_t;
  // read/write data or instruction word
  typedef logic [32-1:0] data_t;
  // access size, log2 of byte count
  typedef logic [2-1:0] size_t;

  ////////////////////
  // bus signals
  ////////////////////

  // request, sampled in the transfer cycle
  typedef struct packed {
    logic  wen;  // write enable
    addr_t adr;
    size_t siz;
    data_t wdt;  // write data
  } tcb_req_t;

  // response, one cycle after the transfer
  typedef struct packed {
    data_t rdt;  // read data
    logic  err;
  } tcb_rsp_t;

  ////////////////////
  // trace records
  ////////////////////

  // fetch address with its instruction word
  typedef struct packed {
    addr_t pc;
    data_t ins;
    logic  err;
  } fetch_rec_t;

  // one load or store with its response
  typedef struct packed {
    logic  wen;
    addr_t adr;
    size_t siz;
    data_t dat;  // wdt for stores, rdt for loads
    logic  err;
  } mem_rec_t;

  // one retired instruction, first memory access only
  typedef struct packed {
    addr_t pc;
    data_t ins;
    logic  fch_err;
    logic  mem;      // access attached
    logic  mem_wen;
    addr_t mem_adr;
    size_t mem_siz;
    data_t mem_dat;
    logic  mem_err;
  } retire_rec_t;

  // merger FSM
  typedef enum logic {
    IDLE,
    PENDING
  } merge_state_t;

endpackage

/* ifu_tracker.sv */
// Fetch tracker
// pairs each IFU fetch address with the instruction word returned one
// cycle later, one fetch record strobe per transfer

module ifu_tracker (
  input  logic                  tcb_ifu,
  input  logic                  reset,
  input  logic                  ifu_vld,
  input  logic                  ifu_rdy,
  input  trace_pkg::tcb_req_t   ifu_req,
  input  trace_pkg::tcb_rsp_t   ifu_rsp,
  output logic                  fch_vld,
  output trace_pkg::fetch_rec_t fch_rec
);

  // handshake in this cycle
  logic             trn;
  // transfer stage
  logic             trn_q;
  trace_pkg::addr_t adr_q;

  assign trn = ifu_vld & ifu_rdy;

  ////////////////////
  // transfer stage
  ////////////////////

  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      trn_q <= 1'b0;
    end else begin
      trn_q <= trn;
    end
  end

  // fetch address, other request fields are of no interest
  always_ff @(posedge tcb_ifu) begin
    if (trn) begin
      adr_q <= ifu_req.adr;
    end
  end

  ////////////////////
  // response stage
  ////////////////////

  // strobe two cycles after the transfer
  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      fch_vld <= 1'b0;
    end else begin
      fch_vld <= trn_q;
    end
  end

  // join address with instruction word and error
  always_ff @(posedge tcb_ifu) begin
    if (trn_q) begin
      fch_rec.pc  <= adr_q;
      fch_rec.ins <= ifu_rsp.rdt;
      fch_rec.err <= ifu_rsp.err;
    end
  end

endmodule

/* lsu_tracker.sv */
// Memory tracker
// pairs each LSU load/store request with its response, one memory
// record strobe per transfer

module lsu_tracker (
  input  logic                tcb_ifu,
  input  logic                reset,
  input  logic                lsu_vld,
  input  logic                lsu_rdy,
  input  trace_pkg::tcb_req_t lsu_req,
  input  trace_pkg::tcb_rsp_t lsu_rsp,
  output logic                mem_vld,
  output trace_pkg::mem_rec_t mem_rec
);

  // handshake in this cycle
  logic                trn;
  // transfer stage
  logic                trn_q;
  trace_pkg::tcb_req_t req_q;
  // record built in the response cycle
  trace_pkg::mem_rec_t rec_nxt;

  assign trn = lsu_vld & lsu_rdy;

  ////////////////////
  // transfer stage
  ////////////////////

  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      trn_q <= 1'b0;
    end else begin
      trn_q <= trn;
    end
  end

  // whole request, write data included
  always_ff @(posedge tcb_ifu) begin
    if (trn) begin
      req_q <= lsu_req;
    end
  end

  ////////////////////
  // response stage
  ////////////////////

  always_comb begin
    rec_nxt.wen = req_q.wen;
    rec_nxt.adr = req_q.adr;
    rec_nxt.siz = req_q.siz;
    // stores log what was written, loads what came back
    if (req_q.wen) begin
      rec_nxt.dat = req_q.wdt;
    end else begin
      rec_nxt.dat = lsu_rsp.rdt;
    end
    // error applies to both directions
    rec_nxt.err = lsu_rsp.err;
  end

  // strobe two cycles after the transfer
  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      mem_vld <= 1'b0;
    end else begin
      mem_vld <= trn_q;
    end
  end

  always_ff @(posedge tcb_ifu) begin
    if (trn_q) begin
      mem_rec <= rec_nxt;
    end
  end

endmodule

/* trace_merger.sv */
// Retirement merger
// holds the pending fetch, attaches the first memory access seen for it,
// emits a retirement record on the next fetch and keeps event counters

module trace_merger #(
  parameter int unsigned CNT_W = 16
)(
  input  logic                   tcb_ifu,
  input  logic                   reset,
  input  logic                   fch_vld,
  input  trace_pkg::fetch_rec_t  fch_rec,
  input  logic                   mem_vld,
  input  trace_pkg::mem_rec_t    mem_rec,
  output logic                   ret_vld,
  output trace_pkg::retire_rec_t ret_rec,
  output logic [CNT_W-1:0]       cnt_ret,
  output logic [CNT_W-1:0]       cnt_ld,
  output logic [CNT_W-1:0]       cnt_st,
  output logic [CNT_W-1:0]       cnt_err,
  output logic [CNT_W-1:0]       cnt_ovf
);

  // FSM and pending instruction
  trace_pkg::merge_state_t state;
  trace_pkg::fetch_rec_t   pnd_fch;
  logic                    pnd_mem;
  trace_pkg::mem_rec_t     pnd_rec;

  logic                    att;      // attach incoming access
  logic                    ovf;      // access dropped
  logic                    emit;     // retire pending instruction
  logic                    mem_any;
  trace_pkg::mem_rec_t     mem_sel;
  trace_pkg::retire_rec_t  ret_nxt;

  ////////////////////
  // attach and emit
  ////////////////////

  always_comb begin
    // mem strobe is taken before a fch strobe of the same cycle
    att     = mem_vld && (state == trace_pkg::PENDING) && !pnd_mem;
    // no instruction yet, or one already has its access
    ovf     = mem_vld && !att;
    emit    = fch_vld && (state == trace_pkg::PENDING);
    mem_any = pnd_mem | att;
    mem_sel = pnd_mem ? pnd_rec : mem_rec;
  end

  // record of the pending instruction, memory fields zero if none
  always_comb begin
    ret_nxt         = '0;
    ret_nxt.pc      = pnd_fch.pc;
    ret_nxt.ins     = pnd_fch.ins;
    ret_nxt.fch_err = pnd_fch.err;
    ret_nxt.mem     = mem_any;
    if (mem_any) begin
      ret_nxt.mem_wen = mem_sel.wen;
      ret_nxt.mem_adr = mem_sel.adr;
      ret_nxt.mem_siz = mem_sel.siz;
      ret_nxt.mem_dat = mem_sel.dat;
      ret_nxt.mem_err = mem_sel.err;
    end
  end

  // FSM, any fetch becomes the new pending instruction
  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      state   <= trace_pkg::IDLE;
      pnd_mem <= 1'b0;
    end else if (fch_vld) begin
      state   <= trace_pkg::PENDING;
      pnd_mem <= 1'b0;
    end else if (att) begin
      pnd_mem <= 1'b1;
    end
  end

  always_ff @(posedge tcb_ifu) begin
    if (fch_vld) begin
      pnd_fch <= fch_rec;
    end
    if (att) begin
      pnd_rec <= mem_rec;
    end
  end

  ////////////////////
  // output
  ////////////////////

  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      ret_vld <= 1'b0;
    end else begin
      ret_vld <= emit;
    end
  end

  always_ff @(posedge tcb_ifu) begin
    if (emit) begin
      ret_rec <= ret_nxt;
    end
  end

  // statistics, wrap at 2**CNT_W
  always_ff @(posedge tcb_ifu) begin
    if (reset) begin
      cnt_ret <= '0;
      cnt_ld  <= '0;
      cnt_st  <= '0;
      cnt_err <= '0;
      cnt_ovf <= '0;
    end else begin
      if (emit) begin
        cnt_ret <= cnt_ret + CNT_W'(1);
      end
      if (emit && mem_any && !mem_sel.wen) begin
        cnt_ld <= cnt_ld + CNT_W'(1);
      end
      if (emit && mem_any && mem_sel.wen) begin
        cnt_st <= cnt_st + CNT_W'(1);
      end
      // either error in the emitted record
      if (emit && (ret_nxt.fch_err || ret_nxt.mem_err)) begin
        cnt_err <= cnt_err + CNT_W'(1);
      end
      if (ovf) begin
        cnt_ovf <= cnt_ovf + CNT_W'(1);
      end
    end
  end

endmodule

/* tcb_trace_mon.sv */
// TCB execution trace monitor
// observes IFU and LSU buses, one retirement record per instruction

module tcb_trace_mon #(
  parameter int unsigned CNT_W = 16
)(
  input  logic                   tcb_ifu,
  input  logic                   reset,
  // instruction fetch bus
  input  logic                   ifu_vld,
  input  logic                   ifu_rdy,
  input  trace_pkg::tcb_req_t    ifu_req,
  input  trace_pkg::tcb_rsp_t    ifu_rsp,
  // load/store bus
  input  logic                   lsu_vld,
  input  logic                   lsu_rdy,
  input  trace_pkg::tcb_req_t    lsu_req,
  input  trace_pkg::tcb_rsp_t    lsu_rsp,
  // retirement trace
  output logic                   ret_vld,
  output trace_pkg::retire_rec_t ret_rec,
  // statistics
  output logic [CNT_W-1:0]       cnt_ret,
  output logic [CNT_W-1:0]       cnt_ld,
  output logic [CNT_W-1:0]       cnt_st,
  output logic [CNT_W-1:0]       cnt_err,
  output logic [CNT_W-1:0]       cnt_ovf
);

  // tracker records into the merger
  logic                  fch_vld;
  trace_pkg::fetch_rec_t fch_rec;
  logic                  mem_vld;
  trace_pkg::mem_rec_t   mem_rec;

  ////////////////////
  // trackers
  ////////////////////

  ifu_tracker u_ifu (
    .tcb_ifu (tcb_ifu),
    .reset   (reset),
    .ifu_vld (ifu_vld),
    .ifu_rdy (ifu_rdy),
    .ifu_req (ifu_req),
    .ifu_rsp (ifu_rsp),
    .fch_vld (fch_vld),
    .fch_rec (fch_rec)
  );

  lsu_tracker u_lsu (
    .tcb_ifu (tcb_ifu),
    .reset   (reset),
    .lsu_vld (lsu_vld),
    .lsu_rdy (lsu_rdy),
    .lsu_req (lsu_req),
    .lsu_rsp (lsu_rsp),
    .mem_vld (mem_vld),
    .mem_rec (mem_rec)
  );

  ////////////////////
  // merger
  ////////////////////

  trace_merger #(
    .CNT_W (CNT_W)
  ) u_mrg (
    .tcb_ifu (tcb_ifu),
    .reset   (reset),
    .fch_vld (fch_vld),
    .fch_rec (fch_rec),
    .mem_vld (mem_vld),
    .mem_rec (mem_rec),
    .ret_vld (ret_vld),
    .ret_rec (ret_rec),
    .cnt_ret (cnt_ret),
    .cnt_ld  (cnt_ld),
    .cnt_st  (cnt_st),
    .cnt_err (cnt_err),
    .cnt_ovf (cnt_ovf)
  );

endmodule

/* tcb_trace_mon_checker.sv */
// Trace monitor checker
// strobe latency of both trackers, merger emit rule and reset state,
// bound into every tcb_trace_mon instance

module tcb_trace_mon_checker #(
  parameter int unsigned CNT_W = 16
)(
  input logic                    tcb_ifu,
  input logic                    reset,
  input logic                    ifu_vld,
  input logic                    ifu_rdy,
  input logic                    lsu_vld,
  input logic                    lsu_rdy,
  input logic                    fch_vld,
  input logic                    mem_vld,
  input logic                    ret_vld,
  input trace_pkg::merge_state_t state,
  input logic [CNT_W-1:0]        cnt_ret,
  input logic [CNT_W-1:0]        cnt_ld,
  input logic [CNT_W-1:0]        cnt_st,
  input logic [CNT_W-1:0]        cnt_err,
  input logic [CNT_W-1:0]        cnt_ovf
);

  // failed assertions so far
  int n_fail = 0;

  ////////////////////
  // reset
  ////////////////////

  // strobes low, FSM idle
  a_rst_strobe: assert property (@(posedge tcb_ifu)
    reset |=> !fch_vld && !mem_vld && !ret_vld && (state == trace_pkg::IDLE))
  else begin
    $error("strobe high or merger busy right after reset");
    n_fail++;
  end

  // all counters cleared
  a_rst_cnt: assert property (@(posedge tcb_ifu)
    reset |=> ((cnt_ret | cnt_ld | cnt_st | cnt_err | cnt_ovf) == '0))
  else begin
    $error("counter not cleared by reset");
    n_fail++;
  end

  ////////////////////
  // strobe timing
  ////////////////////

  // fetch record two cycles after the ifu transfer
  a_fch_lat: assert property (@(posedge tcb_ifu) disable iff (reset)
    !$past(reset) && !$past(reset, 2) |-> fch_vld == $past(ifu_vld && ifu_rdy, 2))
  else begin
    $error("fch_vld does not follow the ifu transfer by two cycles");
    n_fail++;
  end

  // memory record two cycles after the lsu transfer
  a_mem_lat: assert property (@(posedge tcb_ifu) disable iff (reset)
    !$past(reset) && !$past(reset, 2) |-> mem_vld == $past(lsu_vld && lsu_rdy, 2))
  else begin
    $error("mem_vld does not follow the lsu transfer by two cycles");
    n_fail++;
  end

  // retire only on a fetch while an instruction was pending
  a_ret_src: assert property (@(posedge tcb_ifu) disable iff (reset)
    ret_vld && !$past(reset) |-> $past(fch_vld) && ($past(state) == trace_pkg::PENDING))
  else begin
    $error("ret_vld without a fetch in a pending merger");
    n_fail++;
  end

endmodule

bind tcb_trace_mon tcb_trace_mon_checker #(
  .CNT_W (CNT_W)
) u_chk (
  .tcb_ifu (tcb_ifu),
  .reset   (reset),
  .ifu_vld (ifu_vld),
  .ifu_rdy (ifu_rdy),
  .lsu_vld (lsu_vld),
  .lsu_rdy (lsu_rdy),
  .fch_vld (fch_vld),
  .mem_vld (mem_vld),
  .ret_vld (ret_vld),
  .state   (u_mrg.state),
  .cnt_ret (cnt_ret),
  .cnt_ld  (cnt_ld),
  .cnt_st  (cnt_st),
  .cnt_err (cnt_err),
  .cnt_ovf (cnt_ovf)
);

/* tcb_trace_mon_tb.sv */
// Trace monitor testbench
// random IFU/LSU traffic from an LFSR, bus-level reference model of the
// attribution and counter rules, field by field retirement checks

module tcb_trace_mon_tb;

  // narrow counters so a long run wraps them
  localparam int unsigned CNT_W   = 4;
  localparam int          MAX_CYC = 4000;

  // expected counter values at one retirement
  typedef struct packed {
    int ret;
    int ld;
    int st;
    int err;
    int ovf;
  } cnt_snap_t;

  logic                   tcb_ifu = 1'b0;
  logic                   reset;
  logic                   ifu_vld;
  logic                   ifu_rdy;
  trace_pkg::tcb_req_t    ifu_req;
  trace_pkg::tcb_rsp_t    ifu_rsp;
  logic                   lsu_vld;
  logic                   lsu_rdy;
  trace_pkg::tcb_req_t    lsu_req;
  trace_pkg::tcb_rsp_t    lsu_rsp;
  logic                   ret_vld;
  trace_pkg::retire_rec_t ret_rec;
  logic [CNT_W-1:0]       cnt_ret;
  logic [CNT_W-1:0]       cnt_ld;
  logic [CNT_W-1:0]       cnt_st;
  logic [CNT_W-1:0]       cnt_err;
  logic [CNT_W-1:0]       cnt_ovf;

  // reference model state
  logic [31:0]            lfsr = 32'hfafd;
  logic                   have_pnd = 1'b0;
  trace_pkg::retire_rec_t pnd;
  trace_pkg::retire_rec_t exp_q[$];
  cnt_snap_t              snap_q[$];
  int                     n_ret = 0;
  int                     n_ld  = 0;
  int                     n_st  = 0;
  int                     n_err = 0;
  int                     n_ovf = 0;

  always #2 tcb_ifu = ~tcb_ifu;

  tcb_trace_mon #(
    .CNT_W (CNT_W)
  ) UUT (
    .tcb_ifu (tcb_ifu),
    .reset   (reset),
    .ifu_vld (ifu_vld),
    .ifu_rdy (ifu_rdy),
    .ifu_req (ifu_req),
    .ifu_rsp (ifu_rsp),
    .lsu_vld (lsu_vld),
    .lsu_rdy (lsu_rdy),
    .lsu_req (lsu_req),
    .lsu_rsp (lsu_rsp),
    .ret_vld (ret_vld),
    .ret_rec (ret_rec),
    .cnt_ret (cnt_ret),
    .cnt_ld  (cnt_ld),
    .cnt_st  (cnt_st),
    .cnt_err (cnt_err),
    .cnt_ovf (cnt_ovf)
  );

  ////////////////////
  // helpers
  ////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // counter value modulo 2**CNT_W
  function automatic logic [31:0] wrap(input int v);
    return 32'(v & ((1 << CNT_W) - 1));
  endfunction

  task automatic fail_stop();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      fail_stop();
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // transfers of the last cycle with this cycle's responses
  // lsu first, so an access in the cycle of the next fetch stays with the old one
  task automatic model_cycle();
    trace_pkg::retire_rec_t rec;
    cnt_snap_t              snap;
    if (lsu_vld && lsu_rdy) begin
      if (have_pnd && !pnd.mem) begin
        pnd.mem     = 1'b1;
        pnd.mem_wen = lsu_req.wen;
        pnd.mem_adr = lsu_req.adr;
        pnd.mem_siz = lsu_req.siz;
        pnd.mem_dat = lsu_req.wen ? lsu_req.wdt : lsu_rsp.rdt;
        pnd.mem_err = lsu_rsp.err;
      end else begin
        n_ovf++;
      end
    end
    if (ifu_vld && ifu_rdy) begin
      if (have_pnd) begin
        n_ret++;
        if (pnd.mem && pnd.mem_wen) n_st++;
        if (pnd.mem && !pnd.mem_wen) n_ld++;
        if (pnd.fch_err || pnd.mem_err) n_err++;
        exp_q.push_back(pnd);
        snap.ret = n_ret;
        snap.ld  = n_ld;
        snap.st  = n_st;
        snap.err = n_err;
        snap.ovf = n_ovf;
        snap_q.push_back(snap);
      end
      rec         = '0;
      rec.pc      = ifu_req.adr;
      rec.ins     = ifu_rsp.rdt;
      rec.fch_err = ifu_rsp.err;
      pnd         = rec;
      have_pnd    = 1'b1;
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  // probabilities in sixteenths
  task automatic drive_cycle(input int p_ifu, input int p_lsu, input int p_rdy);
    @(posedge tcb_ifu);
    #1;
    ifu_rsp.rdt = rand_bits(32);
    ifu_rsp.err = (rand_bits(4) == 0);
    lsu_rsp.rdt = rand_bits(32);
    lsu_rsp.err = (rand_bits(4) == 0);
    model_cycle();
    ifu_vld     = (rand_bits(4) < p_ifu);
    ifu_rdy     = (rand_bits(4) < p_rdy);
    ifu_req.wen = 1'b0;
    ifu_req.adr = rand_bits(32);
    ifu_req.siz = 2'd2;
    ifu_req.wdt = '0;
    lsu_vld     = (rand_bits(4) < p_lsu);
    lsu_rdy     = (rand_bits(4) < p_rdy);
    lsu_req.wen = 1'(rand_bits(1));
    lsu_req.adr = rand_bits(32);
    lsu_req.siz = 2'(rand_bits(2));
    lsu_req.wdt = rand_bits(32);
  endtask

  initial begin
    reset   = 1'b1;
    ifu_vld = 1'b0;
    ifu_rdy = 1'b0;
    ifu_req = '0;
    ifu_rsp = '0;
    lsu_vld = 1'b0;
    lsu_rdy = 1'b0;
    lsu_req = '0;
    lsu_rsp = '0;
    repeat (5) @(posedge tcb_ifu);
    #1;
    reset = 1'b0;
    check_value("ret_vld", 32'd0, 32'(ret_vld));
    check_value("cnt_ret", 32'd0, 32'(cnt_ret));
    check_value("cnt_ld", 32'd0, 32'(cnt_ld));
    check_value("cnt_st", 32'd0, 32'(cnt_st));
    check_value("cnt_err", 32'd0, 32'(cnt_err));
    check_value("cnt_ovf", 32'd0, 32'(cnt_ovf));
    // accesses before any fetch
    repeat (2) drive_cycle(0, 16, 16);
    // fetch only, with stalls and back-to-back transfers
    repeat (60) drive_cycle(12, 0, 10);
    // mixed traffic, then heavy lsu for extra accesses
    repeat (500) drive_cycle(10, 8, 12);
    repeat (150) drive_cycle(6, 14, 14);
    // drain, bus idle
    for (int i = 0; (i < 20) && (exp_q.size() > 0); i++) begin
      drive_cycle(0, 0, 0);
    end
    if (exp_q.size() != 0) begin
      $display("retirement records missing after the bus went idle");
      fail_stop();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

  ////////////////////
  // monitors
  ////////////////////

  always @(negedge tcb_ifu) begin
    trace_pkg::retire_rec_t exp;
    cnt_snap_t              snap;
    if (!reset && ret_vld) begin
      if (exp_q.size() == 0) begin
        $display("retirement at %0t with no instruction expected", $time);
        fail_stop();
      end else begin
        exp  = exp_q.pop_front();
        snap = snap_q.pop_front();
        check_value("ret_rec.pc", exp.pc, ret_rec.pc);
        check_value("ret_rec.ins", exp.ins, ret_rec.ins);
        check_value("ret_rec.fch_err", 32'(exp.fch_err), 32'(ret_rec.fch_err));
        check_value("ret_rec.mem", 32'(exp.mem), 32'(ret_rec.mem));
        check_value("ret_rec.mem_wen", 32'(exp.mem_wen), 32'(ret_rec.mem_wen));
        check_value("ret_rec.mem_adr", exp.mem_adr, ret_rec.mem_adr);
        check_value("ret_rec.mem_siz", 32'(exp.mem_siz), 32'(ret_rec.mem_siz));
        check_value("ret_rec.mem_dat", exp.mem_dat, ret_rec.mem_dat);
        check_value("ret_rec.mem_err", 32'(exp.mem_err), 32'(ret_rec.mem_err));
        check_value("cnt_ret", wrap(snap.ret), 32'(cnt_ret));
        check_value("cnt_ld", wrap(snap.ld), 32'(cnt_ld));
        check_value("cnt_st", wrap(snap.st), 32'(cnt_st));
        check_value("cnt_err", wrap(snap.err), 32'(cnt_err));
        check_value("cnt_ovf", wrap(snap.ovf), 32'(cnt_ovf));
      end
    end
  end

  // bound assertion failures end the run here
  always @(negedge tcb_ifu) begin
    if (UUT.u_chk.n_fail != 0) begin
      $display("a bound assertion on the monitor failed at %0t", $time);
      fail_stop();
    end
  end

  // watchdog
  initial begin
    repeat (MAX_CYC) @(posedge tcb_ifu);
    $display("simulation did not finish within %0d cycles", MAX_CYC);
    fail_stop();
  end

endmodule

/* list.f */
trace_pkg.sv
ifu_tracker.sv
lsu_tracker.sv
trace_merger.sv
tcb_trace_mon.sv
tcb_trace_mon_checker.sv
tcb_trace_mon_tb.sv

/* Makefile */
SIM   = verilator
FLAGS = --binary --assert --timing -j 0
TOP   = tcb_trace_mon_tb
FLIST = list.f
OBJ   = obj_dir
LOG   = sim.log

SRCS  = $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)

run: compile
	-./$(OBJ)/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
